//--- verilog/game_pkg.sv
package game_pkg;

    // Number of minigame cores that run side by side in the console.
    localparam int NUM_GAMES = 3;

    // Game select code. Values 0 to 2 name a core, 3 means the menu is shown.
    typedef logic [1:0] game_sel_t;

    localparam game_sel_t SEL_MENU = 2'd3;  // No game is active.

    // State code shown on the console. The menu adds its highlighted mode to the base.
    typedef logic [3:0] game_state_t;

    localparam game_state_t ST_IDLE      = 4'd0;  // Core waits for its start pulse.
    localparam game_state_t ST_WAIT      = 4'd1;  // Target is on the LEDs, waiting for a press.
    localparam game_state_t ST_JUDGE     = 4'd2;  // The press is being scored.
    localparam game_state_t ST_DONE      = 4'd3;  // All rounds have been played.
    localparam game_state_t ST_MENU_BASE = 4'd8;  // Menu code is this plus the mode.

    // Saturation limit of the 3-bit score.
    localparam logic [2:0] SCORE_MAX = 3'd7;

    // Everything one core shows on the console, 18 bits in all.
    typedef struct packed {
        logic [2:0]  leds;   // Target index, 0 to 6.
        game_state_t state;  // Current state code.
        logic [6:0]  move;   // Last press, one bit per button.
        logic [2:0]  score;  // Hits so far, stops at 7.
        logic        done;   // High once the game is over.
    } game_status_t;

endpackage

//--- verilog/game_selector.sv
`timescale 1ns/1ps

module game_selector import game_pkg::*; (
    input  logic                 clock,
    input  logic                 arst_n,
    input  game_sel_t            mode,         // Mode switches, a level.
    input  logic                 confirm,      // Confirm button, a level.
    input  logic [6:0]           buttons,      // Play buttons, a level.
    input  logic                 active_done,  // Done flag of the shown game.
    output game_sel_t            minigame,     // Active game or SEL_MENU.
    output game_state_t          menu_state,   // Menu code for the display.
    output logic [NUM_GAMES-1:0] start,        // One-cycle start pulse per core.
    output logic [NUM_GAMES-1:0] press,        // One-cycle press pulse per core.
    output logic [6:0]           press_vec     // Button vector that goes with a press.
);

    game_sel_t  mode_q;        // Sampled mode switches.
    logic       confirm_q;     // Sampled confirm button.
    logic       confirm_prev;  // Confirm as seen one sample earlier.
    logic [6:0] buttons_q;     // Sampled play buttons.
    logic [6:0] buttons_prev;  // Buttons as seen one sample earlier.
    logic       confirm_edge;
    logic       press_edge;
    logic       in_menu;

    // First stage. Every input is sampled once and the previous sample is kept
    // next to it, so the edge detect below works on clean registered values.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mode_q       <= '0;
            confirm_q    <= 1'b0;
            confirm_prev <= 1'b0;
            buttons_q    <= '0;
            buttons_prev <= '0;
        end else begin
            mode_q       <= mode;
            confirm_q    <= confirm;
            confirm_prev <= confirm_q;
            buttons_q    <= buttons;
            buttons_prev <= buttons_q;
        end
    end

    assign confirm_edge = confirm_q && !confirm_prev;  // Rising edge of confirm.

    // A press is counted only when the buttons leave the all-released state.
    // Adding a second button while one is still held does not count again.
    assign press_edge = (buttons_q != '0) && (buttons_prev == '0);

    assign in_menu = (minigame == SEL_MENU);

    // The menu shows its base code plus the highlighted mode.
    assign menu_state = ST_MENU_BASE + game_state_t'(mode_q);

    // Second stage. Selection register and the registered pulses to the cores.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            minigame <= SEL_MENU;
            start    <= '0;
            press    <= '0;
        end else begin
            start <= '0;  // Pulses last exactly one cycle.
            press <= '0;
            if (confirm_edge) begin
                if (in_menu) begin
                    // Mode 3 is not a game, so the menu stays up.
                    if (mode_q != SEL_MENU) begin
                        minigame      <= mode_q;
                        start[mode_q] <= 1'b1;
                    end
                end else if (active_done) begin
                    minigame <= SEL_MENU;  // Game over, back to the menu.
                end
                // Confirm during play is ignored.
            end
            if (press_edge && !in_menu) begin
                press[minigame] <= 1'b1;  // Only the active core hears the press.
            end
        end
    end

    // The button vector is payload. It is held from one press to the next,
    // so the core can take it together with the pulse.
    always_ff @(posedge clock) begin
        if (press_edge && !in_menu) begin
            press_vec <= buttons_q;
        end
    end

endmodule

//--- verilog/game_core.sv
`timescale 1ns/1ps

module game_core import game_pkg::*; #(
    parameter int         ROUNDS = 4,    // Judged rounds before the game is over.
    parameter logic [2:0] SEED   = 3'd1  // LFSR start value, must not be zero.
) (
    input  logic         clock,
    input  logic         arst_n,
    input  logic         start,      // One-cycle pulse, restarts the game.
    input  logic         press,      // One-cycle pulse, a button was pressed.
    input  logic [6:0]   press_vec,  // Buttons that were pressed.
    output game_status_t status      // Everything this core shows.
);

    // Round counter wide enough to hold ROUNDS-1.
    localparam int            RW         = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;
    localparam logic [RW-1:0] LAST_ROUND = RW'(ROUNDS - 1);

    game_state_t   state;          // FSM state.
    logic [2:0]    lfsr;           // Target generator, never zero.
    logic [2:0]    lfsr_next;
    logic [2:0]    target;         // Target index, 0 to 6.
    logic [6:0]    target_onehot;  // Button that scores a hit.
    logic [6:0]    move;           // Last press.
    logic [2:0]    score;          // Hit count.
    logic [RW-1:0] round_cnt;      // Rounds judged so far.
    logic          hit;            // Press matches the target exactly.

    // Taps at x^3 + x^2 + 1 walk all seven nonzero values before repeating.
    assign lfsr_next = {lfsr[1:0], lfsr[2] ^ lfsr[1]};

    assign target        = lfsr - 3'd1;  // Maps 1..7 onto button 0..6.
    assign target_onehot = 7'b1 << target;

    // Two buttons at once or the wrong button both miss.
    assign hit = (press_vec == target_onehot);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            lfsr      <= SEED;
            move      <= '0;
            score     <= '0;
            round_cnt <= '0;
        end else if (start) begin
            // A start wins in every state and begins a fresh game.
            state     <= ST_WAIT;
            lfsr      <= SEED;
            move      <= '0;
            score     <= '0;
            round_cnt <= '0;
        end else begin
            case (state)
                ST_WAIT: begin
                    if (press) begin
                        // The move and the score are taken as the press arrives.
                        // The pulse and its vector are only valid on this cycle.
                        move <= press_vec;
                        if (hit && (score != SCORE_MAX)) begin
                            score <= score + 3'd1;  // Saturates at 7.
                        end
                        state <= ST_JUDGE;
                    end
                end
                ST_JUDGE: begin
                    lfsr <= lfsr_next;  // New target for the next round.
                    if (round_cnt == LAST_ROUND) begin
                        state <= ST_DONE;  // That was the final round.
                    end else begin
                        round_cnt <= round_cnt + 1'b1;
                        state     <= ST_WAIT;
                    end
                end
                default: begin
                    // Idle and done hold until the next start pulse.
                    // Presses seen here are dropped.
                    state <= state;
                end
            endcase
        end
    end

    // Status word for the multiplexer. The LEDs stay dark until the
    // first start so that an idle core shows all zeros.
    always_comb begin
        status.leds  = (state == ST_IDLE) ? 3'd0 : target;
        status.state = state;
        status.move  = move;
        status.score = score;
        status.done  = (state == ST_DONE);
    end

endmodule

//--- verilog/mux_out.sv
`timescale 1ns/1ps

module mux_out import game_pkg::*; (
    input  game_sel_t    minigame,            // Which game is shown.
    input  game_status_t status [NUM_GAMES],  // One status word per core.
    input  game_state_t  menu_state,          // Menu code from the selector.
    output game_status_t status_out,          // What goes to the console pins.
    output logic         active_done          // Done flag of the shown game.
);

    // Pure combinational select, no added latency.
    always_comb begin
        case (minigame)
            2'd0: begin
                status_out = status[0];
            end
            2'd1: begin
                status_out = status[1];
            end
            2'd2: begin
                status_out = status[2];
            end
            default: begin
                // SEL_MENU. Everything dark apart from the menu code.
                status_out.leds  = 3'd0;
                status_out.state = menu_state;
                status_out.move  = 7'd0;
                status_out.score = 3'd0;
                status_out.done  = 1'b0;
            end
        endcase
    end

    // The selector decides on done. It is always low in the menu.
    assign active_done = status_out.done;

endmodule

//--- verilog/game_console_top.sv
`timescale 1ns/1ps

module game_console_top import game_pkg::*; #(
    parameter int         ROUNDS_0 = 4,     // Round count of game 0.
    parameter int         ROUNDS_1 = 6,     // Round count of game 1.
    parameter int         ROUNDS_2 = 9,     // Round count of game 2.
    parameter logic [2:0] SEED_0   = 3'd1,  // First target source of game 0.
    parameter logic [2:0] SEED_1   = 3'd5,  // First target source of game 1.
    parameter logic [2:0] SEED_2   = 3'd6   // First target source of game 2.
) (
    input  logic        clock,
    input  logic        arst_n,
    input  game_sel_t   mode,     // Mode switches.
    input  logic        confirm,  // Confirm button.
    input  logic [6:0]  buttons,  // Play buttons.
    output logic [2:0]  leds,     // Target index of the shown game.
    output game_state_t state,    // State code, or the menu code.
    output logic [6:0]  move,     // Last press of the shown game.
    output logic [2:0]  score,    // Score of the shown game.
    output logic        done      // Shown game is over.
);

    // Per-core settings, picked by generate index below.
    localparam int         ROUNDS_TAB [NUM_GAMES] = '{ROUNDS_0, ROUNDS_1, ROUNDS_2};
    localparam logic [2:0] SEED_TAB   [NUM_GAMES] = '{SEED_0, SEED_1, SEED_2};

    game_sel_t            minigame;
    game_state_t          menu_state;
    logic [NUM_GAMES-1:0] start;
    logic [NUM_GAMES-1:0] press;
    logic [6:0]           press_vec;
    logic                 active_done;
    game_status_t         status [NUM_GAMES];
    game_status_t         status_out;

    game_selector u_selector (
        .clock       (clock),
        .arst_n      (arst_n),
        .mode        (mode),
        .confirm     (confirm),
        .buttons     (buttons),
        .active_done (active_done),
        .minigame    (minigame),
        .menu_state  (menu_state),
        .start       (start),
        .press       (press),
        .press_vec   (press_vec)
    );

    // The cores are the same design and differ only in rounds and seed.
    for (genvar g = 0; g < NUM_GAMES; g++) begin : g_core
        game_core #(
            .ROUNDS (ROUNDS_TAB[g]),
            .SEED   (SEED_TAB[g])
        ) u_core (
            .clock     (clock),
            .arst_n    (arst_n),
            .start     (start[g]),
            .press     (press[g]),
            .press_vec (press_vec),  // Shared, only the pulsed core takes it.
            .status    (status[g])
        );
    end

    mux_out u_mux (
        .minigame    (minigame),
        .status      (status),
        .menu_state  (menu_state),
        .status_out  (status_out),
        .active_done (active_done)
    );

    // Status word out to the pins.
    assign leds  = status_out.leds;
    assign state = status_out.state;
    assign move  = status_out.move;
    assign score = status_out.score;
    assign done  = status_out.done;

endmodule

//--- test/tb_game_console.sv
`timescale 1ns/1ps

module tb_game_console import game_pkg::*; ();

    localparam int WAIT_LIMIT = 20;  // Cycles any single wait may take.

    logic        clock = 1'b0;
    logic        arst_n;
    game_sel_t   mode;
    logic        confirm;
    logic [6:0]  buttons;
    logic [2:0]  leds;
    game_state_t state;
    logic [6:0]  move;
    logic [2:0]  score;
    logic        done;

    int checks   = 0;  // Checks that were evaluated.
    int errors   = 0;  // Checks that failed.
    int timeouts = 0;  // Waits that ran out of time.
    int wait_cycles;   // Falling edges the last state wait took.
    int seed_ret;
    int hits;

    game_console_top DUT (
        .clock   (clock),
        .arst_n  (arst_n),
        .mode    (mode),
        .confirm (confirm),
        .buttons (buttons),
        .leds    (leds),
        .state   (state),
        .move    (move),
        .score   (score),
        .done    (done)
    );

    always #20 clock = ~clock;  // 40 ns period.

    // Compares one value and reports a mismatch when it happens.
    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected)
        else begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // Waits until the shown state is one of two codes. Sampled on the falling edge.
    task automatic wait_for_state(input string name, input game_state_t want_a,
                                  input game_state_t want_b);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && (cycles < WAIT_LIMIT)) begin
            @(negedge clock);
            cycles++;
            seen = (state == want_a) || (state == want_b);
        end
        wait_cycles = cycles;
        if (!seen) begin
            $display("Timeout in %s: state %0d never showed up within %0d cycles, state is %0d.",
                     name, want_a, WAIT_LIMIT, state);
            timeouts++;
        end
    endtask

    task automatic pulse_confirm();
        @(negedge clock);
        confirm = 1'b1;
        @(negedge clock);
        confirm = 1'b0;  // Released so the next confirm gives a new edge.
    endtask

    // Holds the buttons for one cycle, then releases all of them.
    task automatic press_buttons(input logic [6:0] vec);
        @(negedge clock);
        buttons = vec;
        @(negedge clock);
        buttons = 7'd0;
    endtask

    task automatic select_mode(input string name, input game_sel_t m);
        @(negedge clock);
        mode = m;
        wait_for_state(name, ST_MENU_BASE + m, ST_MENU_BASE + m);
    endtask

    // Starts game g from the menu and expects a fresh game.
    task automatic start_game(input string name, input game_sel_t g);
        select_mode(name, g);
        pulse_confirm();
        wait_for_state(name, ST_WAIT, ST_WAIT);
        // The core waits three clocks after the confirm edge, one of them inside pulse_confirm.
        check_value({name, " start latency"}, 2, wait_cycles);
        check_value({name, " score"}, 0, score);
        check_value({name, " move"}, 0, move);
        check_value({name, " done"}, 0, done);
    endtask

    // Plays every round of the running game. With misses on, each round picks a
    // hit, a wrong single button or two buttons. A confirm can be thrown in mid-game.
    task automatic play_game(input string name, input int rounds, input bit misses,
                             input int confirm_round, output int hit_count);
        int         target;
        int         other;
        int         choice;
        logic [6:0] vec;
        hit_count = 0;
        for (int r = 0; r < rounds; r++) begin
            if (r == confirm_round) begin
                pulse_confirm();
                repeat (4) @(negedge clock);
                check_value({name, " confirm in play state"}, ST_WAIT, state);
                check_value({name, " confirm in play score"},
                            (hit_count > 7) ? 7 : hit_count, score);
            end
            check_value({name, " state before press"}, ST_WAIT, state);
            target = leds;
            check_value({name, " target in range"}, 1, int'(target < 7));
            choice = misses ? $urandom_range(2, 0) : 0;
            other  = (target + 1 + $urandom_range(5, 0)) % 7;
            case (choice)
                0:       vec = 7'b1 << target;                      // Exact hit.
                1:       vec = 7'b1 << other;                       // Wrong button.
                default: vec = (7'b1 << target) | (7'b1 << other);  // Two at once.
            endcase
            if (vec == (7'b1 << target)) begin
                hit_count++;
            end
            press_buttons(vec);
            wait_for_state(name, ST_JUDGE, ST_JUDGE);
            // Move and score land three clocks after the button edge.
            // One of those clocks already passed inside press_buttons.
            check_value({name, " judge latency"}, 2, wait_cycles);
            check_value({name, " move"}, vec, move);
            check_value({name, " score"}, (hit_count > 7) ? 7 : hit_count, score);
            wait_for_state(name, ST_WAIT, ST_DONE);
            check_value({name, " round end latency"}, 1, wait_cycles);  // One clock later.
            check_value({name, " state after round"},
                        (r == rounds - 1) ? ST_DONE : ST_WAIT, state);
            check_value({name, " done after round"}, int'(r == rounds - 1), done);
        end
    endtask

    initial begin
        seed_ret = $urandom(52);  // One seed for the whole run.
        arst_n   = 1'b0;
        mode     = 2'd0;
        confirm  = 1'b0;
        buttons  = 7'd0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // Reset puts the console in the menu with everything dark.
        @(negedge clock);
        check_value("reset state", ST_MENU_BASE, state);
        check_value("reset leds", 0, leds);
        check_value("reset move", 0, move);
        check_value("reset score", 0, score);
        check_value("reset done", 0, done);
        select_mode("menu mode 2", 2'd2);
        check_value("menu mode 2 state", ST_MENU_BASE + 2, state);
        select_mode("menu mode 3", 2'd3);
        pulse_confirm();
        repeat (4) @(negedge clock);
        check_value("menu confirm mode 3", ST_MENU_BASE + 3, state);

        // Game 0 played without a miss.
        start_game("game 0 start", 2'd0);
        play_game("game 0", 4, 1'b0, -1, hits);
        check_value("game 0 final score", 4, score);
        check_value("game 0 final state", ST_DONE, state);
        check_value("game 0 final done", 1, done);

        // Confirm after done goes back to the menu.
        pulse_confirm();
        wait_for_state("game 0 exit", ST_MENU_BASE, ST_MENU_BASE);
        check_value("game 0 exit state", ST_MENU_BASE + mode, state);

        // Buttons in the menu reach no core.
        press_buttons(7'b0000100);
        press_buttons(7'b1000001);
        repeat (4) @(negedge clock);
        check_value("menu press state", ST_MENU_BASE, state);
        check_value("menu press score", 0, score);
        check_value("menu press move", 0, move);

        // Game 1 with random hits and misses, over its own six rounds.
        start_game("game 1 start", 2'd1);
        play_game("game 1", 6, 1'b1, -1, hits);
        check_value("game 1 final score", hits, score);
        check_value("game 1 final done", 1, done);
        pulse_confirm();
        wait_for_state("game 1 exit", ST_MENU_BASE + 1, ST_MENU_BASE + 1);

        // Game 2 runs nine hits into a score that stops at 7.
        start_game("game 2 start", 2'd2);
        play_game("game 2", 9, 1'b0, 3, hits);
        check_value("game 2 final score", 7, score);
        check_value("game 2 final state", ST_DONE, state);
        pulse_confirm();
        wait_for_state("game 2 exit", ST_MENU_BASE + 2, ST_MENU_BASE + 2);

        // A second run of game 0 starts from zero.
        start_game("game 0 restart", 2'd0);
        check_value("game 0 restart state", ST_WAIT, state);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
verilog/game_pkg.sv
verilog/game_selector.sv
verilog/game_core.sv
verilog/mux_out.sv
verilog/game_console_top.sv
test/tb_game_console.sv

//--- Bender.yml
package:
  name: game_console

dependencies: {}

sources:
  # RTL in compile order.
  - files:
      - verilog/game_pkg.sv
      - verilog/game_selector.sv
      - verilog/game_core.sv
      - verilog/mux_out.sv
      - verilog/game_console_top.sv

  # Testbench.
  - target: test
    files:
      - test/tb_game_console.sv
